// File: list.f
+incdir+test
rtl/i2c_target_pkg.sv
rtl/i2c_bus_monitor.sv
rtl/i2c_bit_engine.sv
rtl/i2c_target_fsm.sv
rtl/i2c_target.sv
test/tb_i2c_target.sv

// File: rtl/i2c_bit_engine.sv
// Bit level datapath of the I2C target
// Counts bits, shifts in the received byte, captures the host ACK,
// matches the address and picks the bit to transmit
`timescale 1ns/100ps
`default_nettype none

module i2c_bit_engine
  import i2c_target_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sda_i,
  input  logic                 scl_rise_i,
  input  logic                 scl_fall_i,
  input  logic                 start_det_i,
  input  logic                 byte_clr_i,
  input  logic [6:0]           target_address0_i,
  input  logic [6:0]           target_mask0_i,
  input  logic [6:0]           target_address1_i,
  input  logic [6:0]           target_mask1_i,
  input  logic [ByteWidth-1:0] tx_byte_i,
  output logic                 bit_ack_o,
  output logic                 host_ack_o,
  output logic                 address_match_o,
  output logic                 tx_bit_o,
  output logic [ByteWidth-1:0] input_byte_o
);

  logic [3:0]           bit_idx_q;
  logic [ByteWidth-1:0] input_byte_q;
  logic [ByteWidth-1:0] tx_byte_rev;
  logic                 host_ack_q;

  // Index 8 is the ninth bit, ACK or NACK
  assign bit_ack_o = (bit_idx_q == 4'd8);

  // Advance on each SCL fall, wrap after the ACK bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= 4'd0;
    end else if (start_det_i) begin
      bit_idx_q <= 4'd0;
    end else if (scl_fall_i) begin
      if (byte_clr_i || bit_ack_o) begin
        bit_idx_q <= 4'd0;
      end else begin
        bit_idx_q <= bit_idx_q + 4'd1;
      end
    end
  end

  // Data bits enter MSB first, the ninth bit only goes to the ACK flop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      input_byte_q <= '0;
      host_ack_q   <= 1'b0;
    end else if (byte_clr_i) begin
      input_byte_q <= '0;
    end else if (scl_rise_i) begin
      if (bit_ack_o) begin
        host_ack_q <= ~sda_i;
      end else begin
        input_byte_q <= {input_byte_q[ByteWidth-2:0], sda_i};
      end
    end
  end

  // Upper seven bits carry the address, bit 0 is read/write
  assign address_match_o =
      ((input_byte_q[ByteWidth-1:1] & target_mask0_i) == target_address0_i) ||
      ((input_byte_q[ByteWidth-1:1] & target_mask1_i) == target_address1_i);

  // Bit order is reversed so that index 0 selects the MSB
  assign tx_byte_rev  = {<<{tx_byte_i}};
  assign tx_bit_o     = tx_byte_rev[bit_idx_q[2:0]];
  assign host_ack_o   = host_ack_q;
  assign input_byte_o = input_byte_q;

endmodule

`default_nettype wire

// File: rtl/i2c_bus_monitor.sv
// Bus line monitor for the I2C target
// Gives SCL edge strobes and qualified Start and Stop strobes to the rest of the target
`timescale 1ns/100ps
`default_nettype none

module i2c_bus_monitor (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        scl_i,
  input  logic        sda_i,
  input  logic        target_enable_i,
  input  logic [15:0] thd_dat_i,
  output logic        scl_rise_o,
  output logic        scl_fall_o,
  output logic        start_det_o,
  output logic        stop_det_o
);

  // Two stages of line history, the strobes are formed from the registered pair
  logic scl_q, scl_qq;
  logic sda_q, sda_qq;
  logic start_trig, stop_trig;
  logic start_pend_q, stop_pend_q;
  logic [15:0] det_cnt_q;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q  <= 1'b1;
      scl_qq <= 1'b1;
      sda_q  <= 1'b1;
      sda_qq <= 1'b1;
    end else begin
      scl_q  <= scl_i;
      scl_qq <= scl_q;
      sda_q  <= sda_i;
      sda_qq <= sda_q;
    end
  end

  assign scl_rise_o = scl_q & ~scl_qq;
  assign scl_fall_o = ~scl_q & scl_qq;

  // SDA moving while SCL stays high marks a control symbol
  assign start_trig = target_enable_i & scl_q & scl_qq & sda_qq & ~sda_q;
  assign stop_trig  = target_enable_i & scl_q & scl_qq & ~sda_qq & sda_q;

  // One counter serves both conditions since only one can be pending
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      det_cnt_q <= '0;
    end else if (start_trig || stop_trig) begin
      det_cnt_q <= 16'd1;
    end else if (start_pend_q || stop_pend_q) begin
      det_cnt_q <= det_cnt_q + 16'd1;
    end
  end

  // A pending symbol is dropped if SCL falls before the hold time is reached
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_pend_q <= 1'b0;
      stop_pend_q  <= 1'b0;
    end else begin
      if (start_trig) begin
        start_pend_q <= 1'b1;
      end else if (!target_enable_i || !scl_q || start_det_o || stop_trig) begin
        start_pend_q <= 1'b0;
      end
      if (stop_trig) begin
        stop_pend_q <= 1'b1;
      end else if (!target_enable_i || !scl_q || stop_det_o || start_trig) begin
        stop_pend_q <= 1'b0;
      end
    end
  end

  assign start_det_o = target_enable_i & start_pend_q & (det_cnt_q >= thd_dat_i);
  assign stop_det_o  = target_enable_i & stop_pend_q & (det_cnt_q >= thd_dat_i);

endmodule

`default_nettype wire

// File: rtl/i2c_target.sv
// Top level of the I2C target controller
// SDA is open drain, sda_o low means pull the line low
// The ACQ and TX FIFOs live outside and connect through the FIFO ports
`timescale 1ns/100ps
`default_nettype none

module i2c_target
  import i2c_target_pkg::*;
#(
  parameter int  AcqFifoDepth  = 64,
  localparam int AcqDepthWidth = $clog2(AcqFifoDepth + 1)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scl_i,
  input  logic                     sda_i,
  output logic                     sda_o,
  input  logic                     target_enable_i,
  input  logic [15:0]              thd_dat_i,
  input  logic [6:0]               target_address0_i,
  input  logic [6:0]               target_mask0_i,
  input  logic [6:0]               target_address1_i,
  input  logic [6:0]               target_mask1_i,
  input  logic [ByteWidth-1:0]     tx_fifo_rdata_i,
  output logic                     tx_fifo_rready_o,
  output logic                     acq_fifo_wvalid_o,
  output logic [AcqFifoWidth-1:0]  acq_fifo_wdata_o,
  input  logic [AcqDepthWidth-1:0] acq_fifo_depth_i,
  output logic                     acq_fifo_wready_o,
  output logic                     target_idle_o,
  output logic                     target_sr_p_cond_o,
  output logic                     event_target_nack_o,
  output logic                     event_cmd_complete_o,
  output logic                     event_unexp_stop_o
);

  //////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////

  logic                 scl_rise, scl_fall;
  logic                 start_det, stop_det;
  logic                 bit_ack, host_ack, address_match, tx_bit;
  logic                 byte_clr;
  logic [ByteWidth-1:0] input_byte;

  // Line sampling and Start/Stop qualification
  i2c_bus_monitor i_bus_monitor (
    .clk_i, .rst_ni, .scl_i, .sda_i, .target_enable_i, .thd_dat_i,
    .scl_rise_o  (scl_rise),
    .scl_fall_o  (scl_fall),
    .start_det_o (start_det),
    .stop_det_o  (stop_det)
  );

  // Shift register, bit counter and address compare
  i2c_bit_engine i_bit_engine (
    .clk_i, .rst_ni, .sda_i,
    .scl_rise_i      (scl_rise),
    .scl_fall_i      (scl_fall),
    .start_det_i     (start_det),
    .byte_clr_i      (byte_clr),
    .target_address0_i, .target_mask0_i, .target_address1_i, .target_mask1_i,
    .tx_byte_i       (tx_fifo_rdata_i),
    .bit_ack_o       (bit_ack),
    .host_ack_o      (host_ack),
    .address_match_o (address_match),
    .tx_bit_o        (tx_bit),
    .input_byte_o    (input_byte)
  );

  i2c_target_fsm #(
    .AcqFifoDepth (AcqFifoDepth)
  ) i_target_fsm (
    .clk_i, .rst_ni, .target_enable_i, .scl_i,
    .scl_fall_i      (scl_fall),
    .start_det_i     (start_det),
    .stop_det_i      (stop_det),
    .bit_ack_i       (bit_ack),
    .host_ack_i      (host_ack),
    .address_match_i (address_match),
    .tx_bit_i        (tx_bit),
    .input_byte_i    (input_byte),
    .thd_dat_i, .acq_fifo_depth_i, .sda_o,
    .byte_clr_o      (byte_clr),
    .tx_fifo_rready_o, .acq_fifo_wvalid_o, .acq_fifo_wdata_o, .acq_fifo_wready_o,
    .target_idle_o, .target_sr_p_cond_o, .event_target_nack_o,
    .event_cmd_complete_o, .event_unexp_stop_o
  );

endmodule

`default_nettype wire

// File: rtl/i2c_target_fsm.sv
// Protocol state machine of the I2C target
// Drives SDA for ACK, NACK and read data, pushes ACQ entries,
// pops the TX FIFO and raises the event strobes
`timescale 1ns/100ps
`default_nettype none

module i2c_target_fsm
  import i2c_target_pkg::*;
#(
  parameter int  AcqFifoDepth  = 64,
  localparam int AcqDepthWidth = $clog2(AcqFifoDepth + 1)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     target_enable_i,
  input  logic                     scl_i,
  input  logic                     scl_fall_i,
  input  logic                     start_det_i,
  input  logic                     stop_det_i,
  input  logic                     bit_ack_i,
  input  logic                     host_ack_i,
  input  logic                     address_match_i,
  input  logic                     tx_bit_i,
  input  logic [ByteWidth-1:0]     input_byte_i,
  input  logic [15:0]              thd_dat_i,
  input  logic [AcqDepthWidth-1:0] acq_fifo_depth_i,
  output logic                     sda_o,
  output logic                     byte_clr_o,
  output logic                     tx_fifo_rready_o,
  output logic                     acq_fifo_wvalid_o,
  output logic [AcqFifoWidth-1:0]  acq_fifo_wdata_o,
  output logic                     acq_fifo_wready_o,
  output logic                     target_idle_o,
  output logic                     target_sr_p_cond_o,
  output logic                     event_target_nack_o,
  output logic                     event_cmd_complete_o,
  output logic                     event_unexp_stop_o
);

  target_state_e            state_q, state_d;
  acq_fmt_e                 acq_fmt;
  logic [15:0]              tcount_q;
  logic                     load_tcount;
  logic                     hold_done;
  logic                     rw_bit_q;
  logic                     nack_next_byte_q;
  logic                     set_nack, clear_nack;
  logic                     sda_q, sda_d;
  logic                     expect_stop;
  logic [AcqDepthWidth-1:0] acq_free;
  logic                     acq_nearly_full;

  // One slot stays reserved for the Stop or Restart entry
  assign acq_free          = AcqDepthWidth'(AcqFifoDepth) - acq_fifo_depth_i;
  assign acq_nearly_full   = (acq_free <= AcqDepthWidth'(1));
  assign acq_fifo_wready_o = (acq_free > AcqDepthWidth'(2));

  assign target_idle_o = (state_q == Idle);
  assign hold_done     = (tcount_q <= 16'd1);

  //////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    sda_d = 1'b1;
    load_tcount = 1'b0;
    byte_clr_o = 1'b0;
    set_nack = 1'b0;
    clear_nack = 1'b0;
    tx_fifo_rready_o = 1'b0;
    acq_fifo_wvalid_o = 1'b0;
    acq_fmt = AcqData;
    event_cmd_complete_o = 1'b0;
    event_target_nack_o = 1'b0;
    expect_stop = 1'b0;
    unique case (state_q)
      Idle: clear_nack = 1'b1;
      // First SCL fall after the Start begins the address byte
      AcquireStart: begin
        clear_nack = 1'b1;
        if (scl_fall_i) begin
          state_d = AddrRead;
          byte_clr_o = 1'b1;
        end
      end
      // Reads are refused outright when the ACQ FIFO is nearly full,
      // writes get the address ACKed and their first data byte NACKed
      AddrRead: begin
        if (bit_ack_i) begin
          load_tcount = 1'b1;
          if (!address_match_i) begin
            state_d = Idle;
          end else if (acq_nearly_full && input_byte_i[0]) begin
            state_d = NackWait;
          end else begin
            state_d = AddrAckWait;
            set_nack = acq_nearly_full;
          end
        end
      end
      // Hold time after the SCL fall before the ninth bit is driven
      AddrAckWait, AcquireAckWait, NackWait: begin
        if (hold_done && !scl_i) begin
          state_d = target_state_e'(state_q + 5'd1);
        end
      end
      AddrAckSetup, AcquireAckSetup, NackSetup: begin
        sda_d = (state_q == NackSetup);
        if (scl_i) begin
          state_d = target_state_e'(state_q + 5'd1);
        end
      end
      AddrAckPulse, AcquireAckPulse, NackPulse: begin
        sda_d = (state_q == NackPulse);
        if (scl_fall_i) begin
          state_d = target_state_e'(state_q + 5'd1);
          load_tcount = 1'b1;
        end
      end
      AddrAckHold: begin
        sda_d = 1'b0;
        if (hold_done) begin
          acq_fifo_wvalid_o = 1'b1;
          acq_fmt = nack_next_byte_q ? AcqNackStart : AcqStart;
          state_d = rw_bit_q ? TransmitWait : AcquireByte;
        end
      end
      TransmitWait: state_d = TransmitSetup;
      TransmitSetup: begin
        sda_d = tx_bit_i;
        if (scl_i) begin
          state_d = TransmitPulse;
        end
      end
      TransmitPulse: begin
        sda_d = sda_q;
        if (scl_fall_i) begin
          state_d = TransmitHold;
          load_tcount = 1'b1;
        end
      end
      // Keep the data bit for the hold time, then either the next bit or the host ACK
      TransmitHold: begin
        sda_d = sda_q;
        if (hold_done) begin
          state_d = bit_ack_i ? TransmitAck : TransmitSetup;
        end
      end
      TransmitAck: begin
        if (scl_i) begin
          state_d = TransmitAckPulse;
        end
      end
      // The byte is consumed whatever the host answered
      TransmitAckPulse: begin
        if (scl_fall_i) begin
          tx_fifo_rready_o = 1'b1;
          state_d = host_ack_i ? TransmitWait : WaitForStop;
        end
      end
      WaitForStop: expect_stop = 1'b1;
      AcquireByte: begin
        if (bit_ack_i) begin
          load_tcount = 1'b1;
          state_d = (acq_nearly_full || nack_next_byte_q) ? NackWait : AcquireAckWait;
        end
      end
      AcquireAckHold: begin
        sda_d = 1'b0;
        if (hold_done) begin
          acq_fifo_wvalid_o = 1'b1;
          state_d = AcquireByte;
        end
      end
      // No Stop entry follows a NACK from idle, so completion is flagged here
      NackHold: begin
        if (hold_done) begin
          acq_fifo_wvalid_o = 1'b1;
          acq_fmt = AcqNack;
          event_cmd_complete_o = 1'b1;
          event_target_nack_o = 1'b1;
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase

    // Bus conditions override the state outputs and transitions
    if (start_det_i || stop_det_i) begin
      acq_fifo_wvalid_o = !target_idle_o;
      acq_fmt = start_det_i ? AcqRestart : AcqStop;
      event_cmd_complete_o = !target_idle_o;
    end
    if (!target_idle_o && !target_enable_i) begin
      state_d = Idle;
    end else if (start_det_i) begin
      state_d = AcquireStart;
    end else if (stop_det_i) begin
      state_d = Idle;
    end
  end

  assign sda_o              = sda_d;
  assign acq_fifo_wdata_o   = {acq_fmt, input_byte_i};
  assign target_sr_p_cond_o = target_enable_i & !target_idle_o & (start_det_i | stop_det_i);
  // A read should end with a host NACK before the Stop
  assign event_unexp_stop_o = !target_idle_o & rw_bit_q & stop_det_i & !expect_stop;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= Idle;
      sda_q            <= 1'b1;
      tcount_q         <= '1;
      rw_bit_q         <= 1'b0;
      nack_next_byte_q <= 1'b0;
    end else begin
      state_q <= state_d;
      sda_q   <= sda_d;
      // Hold timer, stops at zero
      if (load_tcount) begin
        tcount_q <= thd_dat_i;
      end else if (tcount_q != 16'd0) begin
        tcount_q <= tcount_q - 16'd1;
      end
      if (state_q == AddrRead && bit_ack_i && address_match_i) begin
        rw_bit_q <= input_byte_i[0];
      end
      if (set_nack) begin
        nack_next_byte_q <= 1'b1;
      end else if (clear_nack) begin
        nack_next_byte_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/i2c_target_pkg.sv
// Shared definitions for the I2C target controller
// Holds the byte widths, the ACQ entry format codes and the FSM state encoding
`default_nettype none

package i2c_target_pkg;

  // Width of one data byte on the bus
  localparam int ByteWidth = 8;

  // An ACQ entry is a 3-bit format code on top of one byte
  localparam int AcqFifoWidth = 3 + ByteWidth;

  // Format code in the upper bits of every ACQ entry
  typedef enum logic [2:0] {
    AcqData      = 3'd0,
    AcqStart     = 3'd1,
    AcqStop      = 3'd2,
    AcqRestart   = 3'd3,
    AcqNack      = 3'd4,
    AcqNackStart = 3'd5
  } acq_fmt_e;

  // Each Wait/Setup/Pulse/Hold group is encoded in consecutive order,
  // the FSM steps through a group by adding one to the state
  typedef enum logic [4:0] {
    Idle = 5'h00, AcquireStart = 5'h01, AddrRead = 5'h02,
    AddrAckWait = 5'h03, AddrAckSetup = 5'h04, AddrAckPulse = 5'h05, AddrAckHold = 5'h06,
    TransmitWait = 5'h07, TransmitSetup = 5'h08, TransmitPulse = 5'h09, TransmitHold = 5'h0a,
    TransmitAck = 5'h0b, TransmitAckPulse = 5'h0c, WaitForStop = 5'h0d,
    AcquireByte = 5'h0e,
    AcquireAckWait = 5'h0f, AcquireAckSetup = 5'h10, AcquireAckPulse = 5'h11,
    AcquireAckHold = 5'h12,
    NackWait = 5'h13, NackSetup = 5'h14, NackPulse = 5'h15, NackHold = 5'h16
  } target_state_e;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the I2C target testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f list.f --top-module tb_i2c_target -o sim_tb
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1

// File: test/i2c_host_tasks.svh
// Host side of the I2C bus for the target testbench
// Included inside the testbench module, drives host_scl and host_sda on the falling
// clock edge and samples the wired-AND line in the middle of each SCL high phase

// Start condition from an idle bus, SCL ends low
task automatic bus_start();
  @(negedge clk_i);
  host_sda = 1'b0;
  repeat (10) @(negedge clk_i);
  host_scl = 1'b0;
endtask

// Release SDA with SCL low, raise SCL, then pull SDA low again
task automatic bus_restart();
  repeat (3) @(negedge clk_i);
  host_sda = 1'b1;
  repeat (7) @(negedge clk_i);
  host_scl = 1'b1;
  repeat (10) @(negedge clk_i);
  bus_start();
endtask

// Stop condition, both lines end high
task automatic bus_stop();
  repeat (3) @(negedge clk_i);
  host_sda = 1'b0;
  repeat (7) @(negedge clk_i);
  host_scl = 1'b1;
  repeat (10) @(negedge clk_i);
  host_sda = 1'b1;
  repeat (10) @(negedge clk_i);
endtask

// One SCL period, data set a few clocks after the fall, line sampled mid high phase
task automatic clock_bit(input logic b, output logic s);
  repeat (3) @(negedge clk_i);
  host_sda = b;
  repeat (7) @(negedge clk_i);
  host_scl = 1'b1;
  repeat (5) @(negedge clk_i);
  @(posedge clk_i);
  s = sda_bus;
  repeat (5) @(negedge clk_i);
  host_scl = 1'b0;
endtask

// Eight data bits MSB first, then the ninth bit with SDA released
task automatic write_byte(input logic [7:0] b, output logic nack);
  logic s;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(b[i], s);
  end
  clock_bit(1'b1, nack);
endtask

// Eight bits from the target, then the host ACK (low) or NACK (high)
task automatic read_byte(input logic ack, output logic [7:0] d);
  logic s;
  for (int i = 7; i >= 0; i--) begin
    clock_bit(1'b1, d[i]);
  end
  clock_bit(!ack, s);
endtask

// File: test/tb_i2c_target.sv
// Testbench for the I2C target controller
// A host model drives the bus, FIFO models surround the DUT and every ACQ push,
// ACK bit, TX byte and event is compared with values built from the protocol rules
`timescale 1ns/100ps
`default_nettype none

module tb_i2c_target;
  import i2c_target_pkg::*;

  localparam int Depth = 8;
  localparam logic [6:0] Addr0 = 7'h2A;
  localparam logic [6:0] Addr1 = 7'h50;
  localparam logic [6:0] Mask1 = 7'h70;

  logic clk_i = 1'b0;
  logic rst_ni, host_scl, host_sda, target_enable_i, sda_o;
  logic [7:0] tx_fifo_rdata_i;
  logic [3:0] acq_fifo_depth_i;
  logic tx_fifo_rready_o, acq_fifo_wvalid_o, acq_fifo_wready_o, target_idle_o;
  logic target_sr_p_cond_o, event_target_nack_o, event_cmd_complete_o, event_unexp_stop_o;
  logic [AcqFifoWidth-1:0] acq_fifo_wdata_o;
  wire sda_bus = host_sda & sda_o;

  integer seed;
  int errors = 0;
  int tests = 0;
  int fill = 0;
  int pop_cnt, cmd_cnt, nack_cnt, unexp_cnt, sr_cnt;
  logic [7:0] tx_mem [64];
  logic [5:0] tx_idx = '0;
  logic [AcqFifoWidth-1:0] got_q [$];
  // Bit 11 set means the data byte of the entry is compared too
  logic [11:0] exp_q [$];

  always #50 clk_i = ~clk_i;

  i2c_target #(.AcqFifoDepth(Depth)) i_dut (
    .clk_i, .rst_ni, .scl_i(host_scl), .sda_i(sda_bus), .sda_o, .target_enable_i,
    .thd_dat_i(16'd2), .target_address0_i(Addr0), .target_mask0_i(7'h7F),
    .target_address1_i(Addr1), .target_mask1_i(Mask1), .tx_fifo_rdata_i,
    .tx_fifo_rready_o, .acq_fifo_wvalid_o, .acq_fifo_wdata_o, .acq_fifo_depth_i,
    .acq_fifo_wready_o, .target_idle_o, .target_sr_p_cond_o, .event_target_nack_o,
    .event_cmd_complete_o, .event_unexp_stop_o
  );

  `include "i2c_host_tasks.svh"

  //////////////////////////////////////////////////
  // FIFO models and event counters
  //////////////////////////////////////////////////

  // Pushes, pops and strobes are taken at the rising edge
  always @(posedge clk_i) begin
    if (acq_fifo_wvalid_o) got_q.push_back(acq_fifo_wdata_o);
    if (tx_fifo_rready_o) begin
      pop_cnt++;
      tx_idx <= tx_idx + 6'd1;
    end
    if (event_cmd_complete_o) cmd_cnt++;
    if (event_target_nack_o) nack_cnt++;
    if (event_unexp_stop_o) unexp_cnt++;
    if (target_sr_p_cond_o) sr_cnt++;
  end

  // Head of the TX FIFO and ACQ depth, filler entries count as occupied
  always @(negedge clk_i) begin
    tx_fifo_rdata_i  <= tx_mem[tx_idx];
    acq_fifo_depth_i <= 4'(fill + got_q.size());
  end

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic clear_state();
    got_q.delete();
    exp_q.delete();
    {pop_cnt, cmd_cnt, nack_cnt, unexp_cnt, sr_cnt} = '0;
  endtask

  task automatic expect_entry(input acq_fmt_e fmt, input logic [7:0] data, input logic care);
    exp_q.push_back({care, fmt, data});
  endtask

  task automatic wait_idle();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 1000 && !seen; i++) begin
      @(negedge clk_i);
      seen = target_idle_o;
    end
    if (!seen) begin
      $display("Timeout: the target did not return to idle at t=%0t", $time);
      errors++;
    end
  endtask

  // Waits for all expected pushes, then compares them in order
  task automatic compare_entries();
    int i;
    for (i = 0; i < 1000 && got_q.size() < exp_q.size(); i++) @(posedge clk_i);
    if (got_q.size() < exp_q.size()) begin
      $display("Timeout: only %0d of %0d ACQ entries arrived", got_q.size(), exp_q.size());
      errors++;
    end
    check("acq entry count", 32'(got_q.size()), 32'(exp_q.size()));
    for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      if (exp_q[i][11]) check("acq_fifo_wdata_o", 32'(got_q[i]), 32'(exp_q[i][10:0]));
      else check("acq_fifo_wdata_o fmt", 32'(got_q[i][10:8]), 32'(exp_q[i][10:8]));
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("%s: %0d errors", name, errors - err0);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic write_test(input int nb);
    logic nack;
    logic [7:0] b;
    int err0;
    err0 = errors;
    clear_state();
    bus_start();
    write_byte({Addr0, 1'b0}, nack);
    check("sda ack on address", 32'(nack), 0);
    expect_entry(AcqStart, {Addr0, 1'b0}, 1'b1);
    for (int k = 0; k < nb; k++) begin
      b = 8'($random(seed));
      write_byte(b, nack);
      check("sda ack on data", 32'(nack), 0);
      expect_entry(AcqData, b, 1'b1);
    end
    bus_stop();
    expect_entry(AcqStop, 8'h00, 1'b0);
    compare_entries();
    check("event_cmd_complete_o count", 32'(cmd_cnt), 1);
    end_test("write to pair 0", err0);
  endtask

  task automatic read_test(input int nb, input logic last_ack);
    logic nack;
    logic [7:0] d;
    logic [5:0] first;
    int err0;
    err0 = errors;
    clear_state();
    first = tx_idx;
    bus_start();
    write_byte({Addr1[6:4], 4'($random(seed)), 1'b1}, nack);
    check("sda ack on read address", 32'(nack), 0);
    for (int k = 0; k < nb; k++) begin
      read_byte((k < nb - 1) || last_ack, d);
      check("read data", 32'(d), 32'(tx_mem[6'(first + 6'(k))]));
    end
    bus_stop();
    wait_idle();
    check("tx_fifo_rready_o count", 32'(pop_cnt), 32'(nb));
    check("event_unexp_stop_o count", 32'(unexp_cnt), 32'(last_ack));
    end_test(last_ack ? "read ending in ACK" : "read ending in NACK", err0);
  endtask

  initial begin
    logic nack;
    logic [7:0] b1, b2;
    int err0;
    seed = 29477;
    rst_ni = 1'b0;
    host_scl = 1'b1;
    host_sda = 1'b1;
    target_enable_i = 1'b1;
    tx_fifo_rdata_i = '0;
    acq_fifo_depth_i = '0;
    // MSB set so that a read cut short by Stop leaves SDA released
    for (int i = 0; i < 64; i++) tx_mem[i] = 8'($random(seed)) | 8'h80;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (4) @(negedge clk_i);

    for (int t = 0; t < 3; t++) write_test(1 + ($random(seed) & 3));

    // Address outside both pairs
    err0 = errors;
    clear_state();
    bus_start();
    write_byte({3'b001, 4'($random(seed)), 1'b0}, nack);
    check("sda on unmatched address", 32'(nack), 1);
    wait_idle();
    bus_stop();
    repeat (4) @(negedge clk_i);
    check("acq entry count", 32'(got_q.size()), 0);
    end_test("unmatched address", err0);

    read_test(1 + ($random(seed) & 3), 1'b0);
    read_test(1 + ($random(seed) & 3), 1'b1);

    // Repeated Start within a write
    err0 = errors;
    clear_state();
    b1 = 8'($random(seed));
    b2 = 8'($random(seed));
    bus_start();
    write_byte({Addr0, 1'b0}, nack);
    write_byte(b1, nack);
    bus_restart();
    write_byte({Addr0, 1'b0}, nack);
    check("sda ack after restart", 32'(nack), 0);
    write_byte(b2, nack);
    bus_stop();
    expect_entry(AcqStart, {Addr0, 1'b0}, 1'b1);
    expect_entry(AcqData, b1, 1'b1);
    expect_entry(AcqRestart, 8'h00, 1'b0);
    expect_entry(AcqStart, {Addr0, 1'b0}, 1'b1);
    expect_entry(AcqData, b2, 1'b1);
    expect_entry(AcqStop, 8'h00, 1'b0);
    compare_entries();
    // Restart and the final Stop both come while not idle
    check("target_sr_p_cond_o count", 32'(sr_cnt), 2);
    end_test("repeated start", err0);

    // ACQ FIFO nearly full
    err0 = errors;
    clear_state();
    fill = 5;
    repeat (2) @(negedge clk_i);
    @(posedge clk_i);
    check("acq_fifo_wready_o at 3 free", 32'(acq_fifo_wready_o), 1);
    fill = 6;
    repeat (2) @(negedge clk_i);
    @(posedge clk_i);
    check("acq_fifo_wready_o at 2 free", 32'(acq_fifo_wready_o), 0);
    fill = 7;
    b1 = 8'($random(seed));
    bus_start();
    write_byte({Addr0, 1'b0}, nack);
    check("sda ack on address when full", 32'(nack), 0);
    write_byte(b1, nack);
    check("sda on data when full", 32'(nack), 1);
    wait_idle();
    bus_stop();
    expect_entry(AcqNackStart, {Addr0, 1'b0}, 1'b1);
    expect_entry(AcqNack, b1, 1'b1);
    compare_entries();
    check("event_target_nack_o count", 32'(nack_cnt), 1);
    check("event_cmd_complete_o count", 32'(cmd_cnt), 1);
    clear_state();
    bus_start();
    write_byte({Addr1, 1'b1}, nack);
    check("sda on read address when full", 32'(nack), 1);
    wait_idle();
    bus_stop();
    check("event_target_nack_o count", 32'(nack_cnt), 1);
    fill = 0;
    end_test("acq nearly full", err0);

    // Enable dropped in the middle of a write byte
    err0 = errors;
    clear_state();
    b1 = 8'($random(seed));
    bus_start();
    write_byte({Addr0, 1'b0}, nack);
    // Only the entry of the ACKed address may exist once the target is disabled
    expect_entry(AcqStart, {Addr0, 1'b0}, 1'b1);
    for (int i = 7; i >= 4; i--) clock_bit(b1[i], nack);
    target_enable_i = 1'b0;
    wait_idle();
    for (int i = 3; i >= 0; i--) clock_bit(b1[i], nack);
    clock_bit(1'b1, nack);
    check("sda after disable", 32'(nack), 1);
    bus_stop();
    compare_entries();
    target_enable_i = 1'b1;
    end_test("enable dropped", err0);

    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
